// ==== flist.f ====
+incdir+verilog
verilog/neander_pkg.sv
verilog/neander_ifs.sv
verilog/neander_alu.sv
verilog/addr_unit.sv
verilog/data_unit.sv
verilog/neander_dp.sv
sim/tb_clock.sv
sim/tb_neander_dp.sv

// ==== sim/tb_neander_dp.sv ====
/*
 * Testbench for the datapath top: table of control words and expected
 * register, flag and address values, applied in a loop with a timeout
 */
`timescale 1ns/100ps
`include "neander_defs.svh"

module tb_neander_dp import neander_pkg::*; ();

    // Control word bit layout ------------------------------
    localparam logic [31:0] PC_INC = 32'h1,    PC_LD  = 32'h2,    SP_INC = 32'h4;
    localparam logic [31:0] SP_DEC = 32'h8,    REM_LD = 32'h10,   IDX    = 32'h20;
    localparam logic [31:0] RDM_LD = 32'h40,   RI_LD  = 32'h80,   AC_LD  = 32'h100;
    localparam logic [31:0] X_LD   = 32'h200,  X_INC  = 32'h400,  X_FROM_AC = 32'h800;
    localparam logic [31:0] NZ_LD  = 32'h1000, C_LD   = 32'h2000;
    localparam logic [31:0] ALU_WR = AC_LD | NZ_LD | C_LD;       // Full ALU writeback
    // Load and step bits, dropped after their one edge
    localparam logic [31:0] STROBES = PC_INC | PC_LD | SP_INC | SP_DEC | REM_LD | RDM_LD
                                    | RI_LD | AC_LD | X_LD | X_INC | NZ_LD | C_LD;

    logic        clk, reset;
    logic [31:0] cw;                    // Packed control word
    word_t       din;                   // mem_data_in
    word_t       mem_addr, mem_data_out, dbg_pc, dbg_ac, dbg_sp, dbg_x;
    nibble_t     opcode, sub_opcode;
    logic        flag_n, flag_z, flag_c;
    logic [31:0] ctrl_q[$];
    word_t       din_q[$];
    logic [63:0] exp_q[$];              // {pc, ac, sp, x, addr, dout, ri, nzc}
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cur_row = 0;

    tb_clock #(.PERIOD(40), .RESET_CYCLES(2)) clkgen (.clk(clk), .reset(reset));

    neander_dp neander_dp_i (
        .clk(clk), .reset(reset),
        .pc_inc(cw[0]), .pc_load(cw[1]), .sp_inc(cw[2]), .sp_dec(cw[3]),
        .rem_load(cw[4]), .addr_sel(cw[15:14]), .indexed_mode(cw[5]),
        .rdm_load(cw[6]), .ri_load(cw[7]), .ac_load(cw[8]), .ac_src_sel(cw[17:16]),
        .x_load(cw[9]), .x_inc(cw[10]), .x_src_sel(cw[11]),
        .nz_load(cw[12]), .c_load(cw[13]), .alu_op(cw[21:18]),
        .alu_b_sel(cw[23:22]), .mem_src_sel(cw[25:24]),
        .mem_data_in(din), .mem_addr(mem_addr), .mem_data_out(mem_data_out),
        .opcode(opcode), .sub_opcode(sub_opcode),
        .flag_n(flag_n), .flag_z(flag_z), .flag_c(flag_c),
        .dbg_pc(dbg_pc), .dbg_ac(dbg_ac), .dbg_sp(dbg_sp), .dbg_x(dbg_x)
    );

    // Select fields placed into the control word
    function automatic logic [31:0] addr_src(input logic [1:0] v);
        return 32'(v) << 14;
    endfunction
    function automatic logic [31:0] ac_src(input logic [1:0] v);
        return 32'(v) << 16;
    endfunction
    function automatic logic [31:0] alu_fn(input logic [3:0] v);
        return 32'(v) << 18;
    endfunction
    function automatic logic [31:0] wr_src(input logic [1:0] v);
        return 32'(v) << 24;
    endfunction

    task automatic add_row(input logic [31:0] c, input word_t d, input logic [63:0] e);
        ctrl_q.push_back(c);
        din_q.push_back(d);
        exp_q.push_back(e);
    endtask

    task automatic check(input string what, input logic [7:0] got, input logic [7:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %0t ns row %0d: %s got %h expected %h", $time, cur_row, what,
                     got, want);
        end
    endtask

    task automatic check_row(input logic [63:0] e);
        check("pc", dbg_pc, e[63:56]);
        check("ac", dbg_ac, e[55:48]);
        check("sp", dbg_sp, e[47:40]);
        check("x", dbg_x, e[39:32]);
        check("mem_addr", mem_addr, e[31:24]);
        check("mem_data_out", mem_data_out, e[23:16]);
        check("opcode", {4'h0, opcode}, {4'h0, e[15:12]});
        check("sub_opcode", {4'h0, sub_opcode}, {4'h0, e[11:8]});
        check("flags nzc", {5'b0, flag_n, flag_z, flag_c}, e[7:0]);
    endtask

    // Cycle limit from the table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 2 * exp_q.size() + 20) begin
            $display("Timeout: the table did not finish within %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        cw  = '0;
        din = '0;
        // control word                                   din    pc_ac_sp_x__ad_do_ri_nzc
        add_row('0,                                       8'h00, 64'h00_00_FF_00_00_00_00_00);
        // Fetch ------------------------------
        add_row(PC_INC,                                   8'h00, 64'h01_00_FF_00_00_00_00_00);
        add_row(REM_LD | addr_src(`ADDR_SEL_PC),          8'h00, 64'h01_00_FF_00_01_00_00_00);
        add_row(RDM_LD | PC_INC,                          8'hA3, 64'h02_00_FF_00_01_00_00_00);
        add_row(RI_LD,                                    8'h00, 64'h02_00_FF_00_01_00_A3_00);
        // ALU and flags ------------------------------
        add_row(AC_LD | NZ_LD | ac_src(`AC_SRC_MEM),      8'hF0, 64'h02_F0_FF_00_01_F0_A3_04);
        add_row(ALU_WR | alu_fn(`ALU_ADD),                8'h20, 64'h02_10_FF_00_01_10_A3_01);
        add_row(ALU_WR | alu_fn(`ALU_ADC),                8'h05, 64'h02_16_FF_00_01_16_A3_00);
        add_row(ALU_WR | alu_fn(`ALU_SUB),                8'h16, 64'h02_00_FF_00_01_00_A3_02);
        add_row(ALU_WR | alu_fn(`ALU_SUB),                8'h01, 64'h02_FF_FF_00_01_FF_A3_05);
        add_row(ALU_WR | alu_fn(`ALU_AND),                8'h3C, 64'h02_3C_FF_00_01_3C_A3_00);
        add_row(ALU_WR | alu_fn(`ALU_OR),                 8'hC1, 64'h02_FD_FF_00_01_FD_A3_04);
        add_row(ALU_WR | alu_fn(`ALU_SHL),                8'h00, 64'h02_FA_FF_00_01_FA_A3_05);
        add_row(ALU_WR | alu_fn(`ALU_XOR),                8'h0F, 64'h02_F5_FF_00_01_F5_A3_04);
        add_row(ALU_WR | alu_fn(`ALU_SHR),                8'h00, 64'h02_7A_FF_00_01_7A_A3_01);
        add_row(ALU_WR | alu_fn(`ALU_NOT),                8'h00, 64'h02_85_FF_00_01_85_A3_04);
        add_row(ALU_WR | alu_fn(`ALU_NEG),                8'h00, 64'h02_7B_FF_00_01_7B_A3_01);
        // Index register ------------------------------
        add_row(X_LD,                                     8'h40, 64'h02_7B_FF_40_01_7B_A3_01);
        add_row(X_LD | X_FROM_AC,                         8'h00, 64'h02_7B_FF_7B_01_7B_A3_01);
        add_row(X_LD,                                     8'hFF, 64'h02_7B_FF_FF_01_7B_A3_01);
        add_row(AC_LD | NZ_LD | ac_src(`AC_SRC_X),        8'h00, 64'h02_FF_FF_FF_01_FF_A3_05);
        add_row(X_INC,                                    8'h00, 64'h02_FF_FF_00_01_FF_A3_05);
        add_row(X_LD,                                     8'h70, 64'h02_FF_FF_70_01_FF_A3_05);
        add_row(REM_LD | addr_src(`ADDR_SEL_RDM),         8'h00, 64'h02_FF_FF_70_A3_FF_A3_05);
        add_row(IDX,                                      8'h00, 64'h02_FF_FF_70_13_FF_A3_05);
        // Stack and jump ------------------------------
        add_row(SP_DEC,                                   8'h00, 64'h02_FF_FE_70_A3_FF_A3_05);
        add_row(REM_LD | addr_src(`ADDR_SEL_SP) | wr_src(`MEM_SRC_PC),
                                                          8'h00, 64'h02_FF_FE_70_FE_02_A3_05);
        add_row(RDM_LD,                                   8'h5C, 64'h02_FF_FE_70_FE_FF_A3_05);
        add_row(PC_LD,                                    8'h00, 64'h5C_FF_FE_70_FE_FF_A3_05);
        add_row(SP_INC,                                   8'h00, 64'h5C_FF_FF_70_FE_FF_A3_05);
        add_row(RDM_LD,                                   8'h90, 64'h5C_FF_FF_70_FE_FF_A3_05);
        add_row(PC_LD | PC_INC,                           8'h00, 64'h90_FF_FF_70_FE_FF_A3_05);

        wait (!reset);
        for (int i = 0; i < ctrl_q.size(); i++) begin
            @(posedge clk);
            cw  <= ctrl_q[i];
            din <= din_q[i];
            @(posedge clk);                     // Registers capture here
            cw  <= ctrl_q[i] & ~STROBES;        // Keep selects, drop loads
            @(negedge clk);
            cur_row = i;
            check_row(exp_q[i]);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== sim/tb_clock.sv ====
/*
 * Testbench clock and reset generator
 */
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD       = 40,    // ns
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // Reset released on a rising edge after RESET_CYCLES edges
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== verilog/neander_dp.sv ====
/*
 * Datapath top: plain control ports packed into
 * the address-control and ALU interfaces, three units wired up
 */
`timescale 1ns/100ps

module neander_dp import neander_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    // Address control
    input  logic       pc_inc,
    input  logic       pc_load,
    input  logic       sp_inc,
    input  logic       sp_dec,
    input  logic       rem_load,
    input  addr_sel_t  addr_sel,
    input  logic       indexed_mode,
    // Data control
    input  logic       rdm_load,
    input  logic       ri_load,
    input  logic       ac_load,
    input  ac_src_t    ac_src_sel,
    input  logic       x_load,
    input  logic       x_inc,
    input  x_src_t     x_src_sel,
    input  logic       nz_load,
    input  logic       c_load,
    input  alu_op_t    alu_op,
    input  alu_b_sel_t alu_b_sel,
    input  mem_src_t   mem_src_sel,
    // Memory, asynchronous read
    input  word_t      mem_data_in,
    output word_t      mem_addr,
    output word_t      mem_data_out,
    // To control unit
    output nibble_t    opcode,
    output nibble_t    sub_opcode,
    output logic       flag_n,
    output logic       flag_z,
    output logic       flag_c,
    // Debug taps
    output word_t      dbg_pc,
    output word_t      dbg_ac,
    output word_t      dbg_sp,
    output word_t      dbg_x
);

    word_t pc, sp, ac, x, rdm;

    addr_ctrl_if ctrl_bus ();
    alu_if       alu_bus ();

    // Control word into the address bundle
    assign ctrl_bus.pc_inc       = pc_inc;
    assign ctrl_bus.pc_load      = pc_load;
    assign ctrl_bus.sp_inc       = sp_inc;
    assign ctrl_bus.sp_dec       = sp_dec;
    assign ctrl_bus.rem_load     = rem_load;
    assign ctrl_bus.addr_sel     = addr_sel;
    assign ctrl_bus.indexed_mode = indexed_mode;

    // Units ------------------------------
    addr_unit u_addr (
        .clk(clk), .reset(reset), .ctrl(ctrl_bus.unit),
        .rdm(rdm), .x(x), .pc(pc), .sp(sp), .mem_addr(mem_addr)
    );

    data_unit u_data (
        .clk(clk), .reset(reset),
        .rdm_load(rdm_load), .ri_load(ri_load), .ac_load(ac_load),
        .x_load(x_load), .x_inc(x_inc), .nz_load(nz_load), .c_load(c_load),
        .ac_src_sel(ac_src_sel), .x_src_sel(x_src_sel),
        .mem_src_sel(mem_src_sel), .alu_b_sel(alu_b_sel), .alu_op(alu_op),
        .mem_data_in(mem_data_in), .pc(pc), .alu(alu_bus.client),
        .rdm(rdm), .x(x), .ac(ac),
        .opcode(opcode), .sub_opcode(sub_opcode), .mem_data_out(mem_data_out),
        .flag_n(flag_n), .flag_z(flag_z), .flag_c(flag_c)
    );

    neander_alu u_alu (
        .alu(alu_bus.alu)
    );

    // Register taps for the control unit and debug
    assign dbg_pc = pc;
    assign dbg_ac = ac;
    assign dbg_sp = sp;
    assign dbg_x  = x;

endmodule

// ==== verilog/data_unit.sv ====
/*
 * Data unit: RDM, RI, AC, X and NZC flags,
 * register input muxes, ALU operand B and memory write data
 */
`timescale 1ns/100ps
`include "neander_defs.svh"

module data_unit import neander_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       rdm_load,
    input  logic       ri_load,
    input  logic       ac_load,
    input  logic       x_load,
    input  logic       x_inc,
    input  logic       nz_load,
    input  logic       c_load,
    input  ac_src_t    ac_src_sel,
    input  x_src_t     x_src_sel,
    input  mem_src_t   mem_src_sel,
    input  alu_b_sel_t alu_b_sel,
    input  alu_op_t    alu_op,
    input  word_t      mem_data_in,
    input  word_t      pc,              // Return address for calls
    alu_if.client      alu,
    output word_t      rdm,
    output word_t      x,
    output word_t      ac,
    output nibble_t    opcode,
    output nibble_t    sub_opcode,
    output word_t      mem_data_out,
    output logic       flag_n,
    output logic       flag_z,
    output logic       flag_c
);

    word_t ri;
    word_t ac_in;
    word_t x_in;
    word_t alu_b;

    // Input muxes ------------------------------
    always_comb begin
        case (ac_src_sel)
            `AC_SRC_ALU: ac_in = alu.result;
            `AC_SRC_MEM: ac_in = mem_data_in;   // LDA, LDI, POP
            `AC_SRC_X:   ac_in = x;             // TXA
            default:     ac_in = alu.result;
        endcase
    end

    assign x_in = (x_src_sel == `X_SRC_AC) ? ac : mem_data_in;  // TAX or LDX

    always_comb begin
        case (alu_b_sel)
            `ALU_B_MEM: alu_b = mem_data_in;
            `ALU_B_ONE: alu_b = word_t'(1);     // INC and DEC
            `ALU_B_X:   alu_b = x;
            default:    alu_b = mem_data_in;
        endcase
    end

    // Memory write data
    always_comb begin
        case (mem_src_sel)
            `MEM_SRC_AC: mem_data_out = ac;     // STA, PUSH
            `MEM_SRC_PC: mem_data_out = pc;     // CALL
            `MEM_SRC_X:  mem_data_out = x;      // STX
            default:     mem_data_out = ac;
        endcase
    end

    // ALU hookup: A is always the accumulator
    assign alu.a        = ac;
    assign alu.b        = alu_b;
    assign alu.op       = alu_op;
    assign alu.carry_in = flag_c;

    // Registers ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdm <= '0;
            ri  <= '0;
            ac  <= '0;
        end else begin
            if (rdm_load) rdm <= mem_data_in;
            if (ri_load)  ri  <= rdm;           // Opcode byte from RDM
            if (ac_load)  ac  <= ac_in;
        end
    end

    // X index register, load before increment
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            x <= '0;
        end else if (x_load) begin
            x <= x_in;
        end else if (x_inc) begin
            x <= x + word_t'(1);                // Wraps FF to 00
        end
    end

    // Flags, N and Z from the AC input, C from the ALU
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flag_n <= 1'b0;
            flag_z <= 1'b0;
            flag_c <= 1'b0;
        end else begin
            if (nz_load) begin
                flag_n <= ac_in[`NEANDER_DATA_W-1];
                flag_z <= (ac_in == '0);
            end
            if (c_load) flag_c <= alu.carry_out;
        end
    end

    assign opcode     = ri[`NEANDER_DATA_W-1:`NEANDER_DATA_W/2];
    assign sub_opcode = ri[`NEANDER_DATA_W/2-1:0];  // Stack and index variants

    // Control word checks ------------------------------
    mux_codes_a: assert property (
        @(posedge clk) disable iff (reset)
        ac_src_sel != 2'd3 && mem_src_sel != 2'd3 && alu_b_sel != 2'd3
    ) else $error("data select field uses unused code 3");

endmodule

// ==== verilog/addr_unit.sv ====
/*
 * Address unit: PC, SP and REM registers,
 * REM source mux and indexed memory address
 */
`timescale 1ns/100ps
`include "neander_defs.svh"

module addr_unit import neander_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    addr_ctrl_if.unit    ctrl,
    input  word_t        rdm,           // Jump target and direct address
    input  word_t        x,             // Index offset
    output word_t        pc,
    output word_t        sp,
    output word_t        mem_addr
);

    word_t rem;
    word_t rem_in;                      // Output of the source mux

    // Program counter ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (ctrl.pc_load) begin
            pc <= rdm;                  // Jump wins over increment
        end else if (ctrl.pc_inc) begin
            pc <= pc + word_t'(1);
        end
    end

    // Stack pointer ------------------------------
    // Pushes predecrement, so SP points at the last pushed byte
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sp <= `NEANDER_SP_RESET;
        end else if (ctrl.sp_dec) begin
            sp <= sp - word_t'(1);      // Push
        end else if (ctrl.sp_inc) begin
            sp <= sp + word_t'(1);      // Pop
        end
    end

    // REM and its source mux ------------------------------
    always_comb begin
        case (ctrl.addr_sel)
            `ADDR_SEL_RDM: rem_in = rdm;    // Operand address
            `ADDR_SEL_PC:  rem_in = pc;     // Fetch
            `ADDR_SEL_SP:  rem_in = sp;     // Stack access
            default:       rem_in = rdm;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rem <= '0;
        end else if (ctrl.rem_load) begin
            rem <= rem_in;
        end
    end

    // Indexed mode adds X, wrapping at the top of memory
    assign mem_addr = ctrl.indexed_mode ? rem + x : rem;

    // Control word checks ------------------------------
    // Push and pop in the same cycle would lose one of them
    sp_step_excl_a: assert property (
        @(posedge clk) disable iff (reset)
        !(ctrl.sp_inc && ctrl.sp_dec)
    ) else $error("sp_inc and sp_dec both high");

    addr_sel_code_a: assert property (
        @(posedge clk) disable iff (reset)
        ctrl.addr_sel != 2'd3
    ) else $error("addr_sel uses unused code 3");

endmodule

// ==== verilog/neander_alu.sv ====
/*
 * Combinational ALU with carry
 * ADD ADC SUB NEG, logic ops, single-bit shifts
 */
`timescale 1ns/100ps
`include "neander_defs.svh"

module neander_alu import neander_pkg::*; (
    alu_if.alu alu
);

    // Widened by one bit so the top bit holds carry or borrow
    logic [`NEANDER_DATA_W:0] add_full;
    logic [`NEANDER_DATA_W:0] adc_full;
    logic [`NEANDER_DATA_W:0] sub_full;
    word_t                    neg_res;

    assign add_full = {1'b0, alu.a} + {1'b0, alu.b};
    assign adc_full = add_full + {{`NEANDER_DATA_W{1'b0}}, alu.carry_in};
    assign sub_full = {1'b0, alu.a} - {1'b0, alu.b};   // MSB set on borrow
    assign neg_res  = word_t'(0) - alu.a;               // Two's complement

    // Operation select ------------------------------
    always_comb begin
        alu.result    = alu.b;          // Undefined codes pass B
        alu.carry_out = 1'b0;
        case (alu.op)
            `ALU_ADD: begin
                alu.result    = add_full[`NEANDER_DATA_W-1:0];
                alu.carry_out = add_full[`NEANDER_DATA_W];
            end
            `ALU_ADC: begin
                alu.result    = adc_full[`NEANDER_DATA_W-1:0];
                alu.carry_out = adc_full[`NEANDER_DATA_W];
            end
            `ALU_SUB: begin
                alu.result    = sub_full[`NEANDER_DATA_W-1:0];
                alu.carry_out = sub_full[`NEANDER_DATA_W];   // Borrow
            end
            `ALU_AND: alu.result = alu.a & alu.b;
            `ALU_OR:  alu.result = alu.a | alu.b;
            `ALU_XOR: alu.result = alu.a ^ alu.b;
            `ALU_NOT: alu.result = ~alu.a;                   // B ignored
            `ALU_SHL: begin
                // MSB falls out into carry
                alu.result    = {alu.a[`NEANDER_DATA_W-2:0], 1'b0};
                alu.carry_out = alu.a[`NEANDER_DATA_W-1];
            end
            `ALU_SHR: begin
                alu.result    = {1'b0, alu.a[`NEANDER_DATA_W-1:1]};
                alu.carry_out = alu.a[0];                    // LSB out
            end
            `ALU_NEG: begin
                alu.result    = neg_res;
                alu.carry_out = |alu.a;                      // Borrow from 0 - a
            end
            default: begin
                alu.result    = alu.b;
                alu.carry_out = 1'b0;
            end
        endcase
    end

endmodule

// ==== verilog/neander_ifs.sv ====
/*
 * addr_ctrl_if: PC, SP, REM and addressing controls
 * alu_if: operands, operation and result of the ALU
 */
`timescale 1ns/100ps

// ------------------------------
// Address-side control bundle
// ------------------------------
interface addr_ctrl_if import neander_pkg::*; ();
    logic      pc_inc;                  // PC + 1
    logic      pc_load;                 // PC <- RDM, jump target
    logic      sp_inc;                  // Pop
    logic      sp_dec;                  // Push
    logic      rem_load;
    addr_sel_t addr_sel;                // REM source select
    logic      indexed_mode;            // Address = REM + X

    modport ctrl (
        output pc_inc, pc_load, sp_inc, sp_dec,
        output rem_load, addr_sel, indexed_mode
    );

    modport unit (
        input pc_inc, pc_load, sp_inc, sp_dec,
        input rem_load, addr_sel, indexed_mode
    );
endinterface

// ------------------------------
// ALU operand and result bundle
// ------------------------------
interface alu_if import neander_pkg::*; ();
    word_t   a;                         // Always AC
    word_t   b;                         // Selected operand
    alu_op_t op;
    logic    carry_in;                  // From C flag, used by ADC
    word_t   result;
    logic    carry_out;

    // Data unit drives operands
    modport client (output a, b, op, carry_in, input result, carry_out);

    modport alu (input a, b, op, carry_in, output result, carry_out);
endinterface

// ==== verilog/neander_pkg.sv ====
/*
 * Shared datapath types: words, opcode nibbles,
 * ALU operation code and control-word select fields
 */
`include "neander_defs.svh"

package neander_pkg;

    // Data path words ------------------------------

    // Data byte or memory address
    typedef logic [`NEANDER_DATA_W-1:0] word_t;

    // One half of the instruction register
    typedef logic [`NEANDER_DATA_W/2-1:0] nibble_t;

    // Control word fields ---------------------------

    typedef logic [3:0] alu_op_t;       // Codes in ALU_* macros

    // REM source: RDM, PC or SP
    typedef logic [1:0] addr_sel_t;

    // AC source: ALU, memory or X
    typedef logic [1:0] ac_src_t;

    typedef logic [1:0] mem_src_t;      // Write data: AC, PC or X

    // Operand B: memory, constant 1 or X
    typedef logic [1:0] alu_b_sel_t;

    typedef logic       x_src_t;        // X load from memory or AC

endpackage

// ==== verilog/neander_defs.svh ====
/*
 * Datapath width and SP reset value
 * ALU operation codes and control-word select codes
 */
`ifndef NEANDER_DEFS_SVH
`define NEANDER_DEFS_SVH

`define NEANDER_DATA_W    8         // Data and address width
`define NEANDER_SP_RESET  8'hFF     // Stack grows down from top of memory

// ALU operations ------------------------------
`define ALU_ADD  4'd0
`define ALU_AND  4'd1
`define ALU_OR   4'd2
`define ALU_NOT  4'd3
`define ALU_SUB  4'd4
`define ALU_XOR  4'd5
`define ALU_SHL  4'd6
`define ALU_SHR  4'd7
`define ALU_NEG  4'd8
`define ALU_ADC  4'd9

// Select codes --------------------------------
`define ADDR_SEL_RDM  2'd0          // REM source
`define ADDR_SEL_PC   2'd1
`define ADDR_SEL_SP   2'd2
`define AC_SRC_ALU    2'd0          // AC source
`define AC_SRC_MEM    2'd1
`define AC_SRC_X      2'd2
`define X_SRC_MEM     1'd0          // X load source
`define X_SRC_AC      1'd1
`define MEM_SRC_AC    2'd0          // Memory write data
`define MEM_SRC_PC    2'd1
`define MEM_SRC_X     2'd2
`define ALU_B_MEM     2'd0          // ALU operand B
`define ALU_B_ONE     2'd1
`define ALU_B_X       2'd2

`endif
